//--- hdl/pcxt_pkg.sv
// PC/XT chipset glue definitions
`default_nettype none

package pcxt_pkg;

	// Wishbone register port
	typedef logic [1:0]  wb_adr_t;
	typedef logic [31:0] wb_data_t;

	// Joystick words as delivered by the host side
	typedef logic [31:0] joy_digital_t;
	typedef logic [15:0] joy_analog_t;

	// Audio path
	typedef logic signed [15:0] sample_t;
	typedef logic [7:0]         tandy_sample_t;
	typedef logic signed [16:0] mix_t;

	typedef logic [3:0] dip_nibble_t;

	// CPU clock selection, reserved code falls back to 4.77
	typedef enum logic [1:0] {
		SPEED_4_77   = 2'd0,
		SPEED_7_16   = 2'd1,
		SPEED_14_318 = 2'd2,
		SPEED_RSVD   = 2'd3
	} cpu_speed_e;

	// Keyboard line pair
	typedef struct packed {
		logic clk;
		logic data;
	} ps2_lines_t;

	// Raw external clocks, sampled as data
	typedef struct packed {
		logic opl2;
		logic uart;
	} ext_ticks_t;

	////////////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////////////
	localparam wb_adr_t ADR_SYS_CFG = 2'd0;
	localparam wb_adr_t ADR_IO_CFG  = 2'd1;

	// SYS_CFG fields
	localparam int SYS_SOFT_RESET_BIT  = 0;
	localparam int SYS_TANDY_MODEL_BIT = 1;
	localparam int SYS_SPLASH_SKIP_BIT = 2;
	localparam int SYS_CPU_SPEED_LSB   = 3;
	localparam int SYS_CPU_SPEED_MSB   = 4;
	localparam int SYS_CFG_WIDTH       = 5;

	// IO_CFG fields
	localparam int IO_MDA_MODE_BIT = 0;
	localparam int IO_JOY_SWAP_BIT = 1;
	localparam int IO_CFG_WIDTH    = 2;

	// Motherboard DIP switches, CGA 80 column or MDA
	localparam logic [7:0] DIP_CGA80 = 8'b0010_1101;
	localparam logic [7:0] DIP_MDA   = 8'b0011_1101;

endpackage

`default_nettype wire

//--- hdl/platform_cfg_if.sv
// Platform configuration bundle
`timescale 1ns/1ps
`default_nettype none

interface platform_cfg_if;
	import pcxt_pkg::*;

	// Selected CPU rate
	cpu_speed_e cpu_speed;
	// Model captured while reset is held
	logic       tandy_video;
	// Display adapter, 1 selects MDA
	logic       mda_mode;
	// Exchange joystick ports
	logic       joy_swap;
	// Splash screen still running
	logic       splash_active;

	// Register block side
	modport ctrl (
		output cpu_speed,
		output tandy_video,
		output mda_mode,
		output joy_swap,
		output splash_active
	);

	// Datapath side
	modport user (
		input cpu_speed,
		input tandy_video,
		input mda_mode,
		input joy_swap,
		input splash_active
	);

endinterface

`default_nettype wire

//--- hdl/cdc_sync.sv
// Synchronizer with edge detect
`timescale 1ns/1ps
`default_nettype none

module cdc_sync #(
	parameter type payload_t = logic
) (
	input  wire      clk_chipset,
	input  wire      reset_wire,
	input  wire      payload_t async_in,
	output payload_t sync_out,
	output payload_t rose
);

	// First stage, may go metastable
	payload_t meta_q;
	// Copy of sync_out one cycle older
	payload_t prev_q;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			meta_q   <= '0;
			sync_out <= '0;
			prev_q   <= '0;
			rose     <= '0;
		end else begin
			meta_q   <= async_in;
			sync_out <= meta_q;
			prev_q   <= sync_out;
			// One pulse per bit going low to high
			rose     <= payload_t'(sync_out & ~prev_q);
		end
	end

endmodule

`default_nettype wire

//--- hdl/clock_enable_gen.sv
// Chipset clock enable generator
`timescale 1ns/1ps
`default_nettype none

module clock_enable_gen #(
	parameter int BASE_DIV = 4
) (
	input  wire                  clk_chipset,
	input  wire                  reset_wire,
	input  wire                  biu_done,
	input  wire pcxt_pkg::ext_ticks_t ext_ticks,
	platform_cfg_if.user         cfg,
	output logic                 base_ce,
	output logic                 cpu_ce,
	output logic                 peripheral_ce,
	output logic                 opl2_ce,
	output logic                 uart_ce,
	output logic                 turbo_mode
);
	import pcxt_pkg::*;

	localparam int BASE_W = (BASE_DIV > 2) ? $clog2(BASE_DIV) : 1;
	localparam logic [BASE_W-1:0] BASE_LAST = BASE_W'(BASE_DIV - 1);

	logic [BASE_W-1:0] base_cnt;
	logic              div2_q;
	logic [1:0]        div3_q;
	logic              per_q;
	logic              tick_7_16;
	logic              tick_4_77;
	logic              tick_cpu;
	ext_ticks_t        ext_rose;

	////////////////////////////////////////////////////////////////////////////
	// Base rate, stands in for 14.318
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			base_cnt <= '0;
			base_ce  <= 1'b0;
		end else begin
			base_ce  <= (base_cnt == BASE_LAST);
			base_cnt <= (base_cnt == BASE_LAST) ? '0 : base_cnt + 1'b1;
		end
	end

	// Qualified base ticks
	assign tick_7_16 = base_ce & div2_q;
	assign tick_4_77 = base_ce & (div3_q == 2'd2);

	// CPU rate mux
	always_comb begin
		case (cfg.cpu_speed)
			SPEED_14_318: tick_cpu = base_ce;
			SPEED_7_16:   tick_cpu = tick_7_16;
			default:      tick_cpu = tick_4_77;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Derived rates and turbo flag
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			div2_q        <= 1'b0;
			div3_q        <= 2'd0;
			per_q         <= 1'b0;
			cpu_ce        <= 1'b0;
			peripheral_ce <= 1'b0;
			turbo_mode    <= 1'b0;
		end else begin
			if (base_ce) begin
				div2_q <= ~div2_q;
				div3_q <= (div3_q == 2'd2) ? 2'd0 : div3_q + 2'd1;
			end
			// Peripheral clock is 4.77 halved
			if (tick_4_77)
				per_q <= ~per_q;
			cpu_ce        <= tick_cpu;
			peripheral_ce <= tick_4_77 & per_q;
			// Only switch between bus cycles
			if (biu_done)
				turbo_mode <= (cfg.cpu_speed == SPEED_7_16) ||
					(cfg.cpu_speed == SPEED_14_318);
		end
	end

	// OPL2 and UART clocks come in raw
	cdc_sync #(
		.payload_t (ext_ticks_t)
	) u_ext_sync (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.async_in    (ext_ticks),
		.sync_out    (),
		.rose        (ext_rose)
	);

	assign opl2_ce = ext_rose.opl2;
	assign uart_ce = ext_rose.uart;

endmodule

`default_nettype wire

//--- hdl/audio_mixer.sv
// Signed sound mixer
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  wire                     clk_chipset,
	input  wire                     reset_wire,
	input  wire pcxt_pkg::sample_t       opl2_sample,
	input  wire pcxt_pkg::tandy_sample_t tandy_sample,
	input  wire                     speaker,
	output pcxt_pkg::sample_t       audio_out
);
	import pcxt_pkg::*;

	mix_t opl2_term;
	mix_t speaker_term;
	mix_t tandy_term;
	mix_t mix_sum;

	// OPL2 sign extended, x4
	assign opl2_term    = mix_t'({opl2_sample[15], opl2_sample} << 2);
	// Speaker bit lands on weight 32768
	assign speaker_term = mix_t'({1'b0, speaker, 15'd0});
	// Tandy PSG, x64
	assign tandy_term   = mix_t'({3'b000, tandy_sample, 6'd0});
	// Wraps modulo 2^17
	assign mix_sum      = opl2_term + speaker_term + tandy_term;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			audio_out <= '0;
		else
			audio_out <= sample_t'(mix_sum[16:1]);
	end

endmodule

`default_nettype wire

//--- hdl/input_conditioner.sv
// Keyboard, joystick and DIP conditioning
`timescale 1ns/1ps
`default_nettype none

module input_conditioner (
	input  wire                    clk_chipset,
	input  wire                    reset_wire,
	input  wire pcxt_pkg::ps2_lines_t   ps2_in,
	output pcxt_pkg::ps2_lines_t   ps2_out,
	input  wire pcxt_pkg::joy_digital_t joy0_in,
	input  wire pcxt_pkg::joy_digital_t joy1_in,
	input  wire pcxt_pkg::joy_analog_t  joya0_in,
	input  wire pcxt_pkg::joy_analog_t  joya1_in,
	output pcxt_pkg::joy_digital_t joy0,
	output pcxt_pkg::joy_digital_t joy1,
	output pcxt_pkg::joy_analog_t  joya0,
	output pcxt_pkg::joy_analog_t  joya1,
	input  wire [7:0]              port_b_out,
	output pcxt_pkg::dip_nibble_t  port_c_nibble,
	platform_cfg_if.user           cfg
);
	import pcxt_pkg::*;

	// Full switch byte for the current adapter
	logic [7:0] dip_sw;

	// Keyboard lines into the chipset domain
	cdc_sync #(
		.payload_t (ps2_lines_t)
	) u_ps2_sync (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.async_in    (ps2_in),
		.sync_out    (ps2_out),
		.rose        ()
	);

	assign dip_sw = cfg.mda_mode ? DIP_MDA : DIP_CGA80;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			joy0          <= '0;
			joy1          <= '0;
			joya0         <= '0;
			joya1         <= '0;
			port_c_nibble <= '0;
		end else begin
			// Swap moves digital and analog words together
			if (cfg.joy_swap) begin
				joy0  <= joy1_in;
				joy1  <= joy0_in;
				joya0 <= joya1_in;
				joya1 <= joya0_in;
			end else begin
				joy0  <= joy0_in;
				joy1  <= joy1_in;
				joya0 <= joya0_in;
				joya1 <= joya1_in;
			end
			// PPI port B bit 3 picks the switch half on port C
			port_c_nibble <= port_b_out[3] ? dip_sw[7:4] : dip_sw[3:0];
		end
	end

endmodule

`default_nettype wire

//--- hdl/chipset_control.sv
// Chipset control registers and reset
`timescale 1ns/1ps
`default_nettype none

module chipset_control #(
	parameter int POR_CYCLES       = 65535,
	parameter int CPU_RESET_CYCLES = 43,
	parameter int SPLASH_TICKS     = 14318000,
	parameter int SPLASH_SECONDS   = 5
) (
	input  wire                clk_chipset,
	input  wire                reset_wire,
	input  wire                base_ce,
	input  wire                wb_cyc,
	input  wire                wb_stb,
	input  wire                wb_we,
	input  wire pcxt_pkg::wb_adr_t  wb_adr,
	input  wire pcxt_pkg::wb_data_t wb_dat_w,
	output pcxt_pkg::wb_data_t wb_dat_r,
	output logic               wb_ack,
	output logic               sys_reset,
	output logic               cpu_reset,
	platform_cfg_if.ctrl       cfg
);
	import pcxt_pkg::*;

	localparam int TICK_W = (SPLASH_TICKS > 2) ? $clog2(SPLASH_TICKS) : 1;
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);
	localparam int POR_W  = (POR_CYCLES > 2) ? $clog2(POR_CYCLES) : 1;
	localparam int CPU_W  = (CPU_RESET_CYCLES > 2) ? $clog2(CPU_RESET_CYCLES) : 1;

	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(SPLASH_TICKS - 1);
	localparam logic [SEC_W-1:0]  SEC_LAST  = SEC_W'(SPLASH_SECONDS - 1);
	localparam logic [POR_W-1:0]  POR_LAST  = POR_W'(POR_CYCLES - 1);
	localparam logic [CPU_W-1:0]  CPU_LAST  = CPU_W'(CPU_RESET_CYCLES - 1);

	logic [SYS_CFG_WIDTH-1:0] sys_cfg;
	logic [IO_CFG_WIDTH-1:0]  io_cfg;
	logic                     wb_req;
	wb_data_t                 rd_data;
	logic [TICK_W-1:0]        tick_cnt;
	logic [SEC_W-1:0]         sec_cnt;
	logic                     splash_active_q;
	logic                     hold;
	logic [POR_W-1:0]         por_cnt;
	logic [CPU_W-1:0]         cpu_cnt;
	logic                     tandy_video_q;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone registers
	////////////////////////////////////////////////////////////////////////////
	// New request only while no ack is out, one ack per access
	assign wb_req = wb_cyc & wb_stb & ~wb_ack;

	always_comb begin
		rd_data = '0;
		if (wb_adr == ADR_SYS_CFG)
			rd_data[SYS_CFG_WIDTH-1:0] = sys_cfg;
		else if (wb_adr == ADR_IO_CFG)
			rd_data[IO_CFG_WIDTH-1:0] = io_cfg;
	end

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
			sys_cfg  <= '0;
			io_cfg   <= '0;
		end else begin
			wb_ack <= wb_req;
			if (wb_req) begin
				wb_dat_r <= rd_data;
				// Unmapped addresses swallow writes
				if (wb_we && wb_adr == ADR_SYS_CFG)
					sys_cfg <= wb_dat_w[SYS_CFG_WIDTH-1:0];
				else if (wb_we && wb_adr == ADR_IO_CFG)
					io_cfg <= wb_dat_w[IO_CFG_WIDTH-1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Splash timer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active_q <= 1'b1;
			tick_cnt        <= '0;
			sec_cnt         <= '0;
		end else if (splash_active_q) begin
			if (sys_cfg[SYS_SPLASH_SKIP_BIT])
				splash_active_q <= 1'b0;
			else if (base_ce) begin
				// One second of base ticks
				if (tick_cnt == TICK_LAST) begin
					tick_cnt <= '0;
					sec_cnt  <= sec_cnt + 1'b1;
					if (sec_cnt == SEC_LAST)
						splash_active_q <= 1'b0;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reset sequencer
	////////////////////////////////////////////////////////////////////////////
	assign hold = splash_active_q | sys_cfg[SYS_SOFT_RESET_BIT];

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset     <= 1'b1;
			por_cnt       <= '0;
			cpu_reset     <= 1'b1;
			cpu_cnt       <= '0;
			tandy_video_q <= 1'b0;
		end else begin
			// Power-on hold restarts on every hold request
			if (hold) begin
				sys_reset <= 1'b1;
				por_cnt   <= '0;
			end else if (sys_reset) begin
				if (por_cnt == POR_LAST)
					sys_reset <= 1'b0;
				else
					por_cnt <= por_cnt + 1'b1;
			end
			// CPU stays in reset a little longer
			if (sys_reset) begin
				cpu_reset <= 1'b1;
				cpu_cnt   <= '0;
			end else if (cpu_reset) begin
				if (cpu_cnt == CPU_LAST)
					cpu_reset <= 0;
				else
					cpu_cnt <= cpu_cnt + 1'b1;
			end
			// Model only changes across a reset
			if (sys_reset)
				tandy_video_q <= sys_cfg[SYS_TANDY_MODEL_BIT];
		end
	end

	// Decoded fields out to the datapath
	assign cfg.cpu_speed     = cpu_speed_e'(sys_cfg[SYS_CPU_SPEED_MSB:SYS_CPU_SPEED_LSB]);
	assign cfg.tandy_video   = tandy_video_q;
	assign cfg.mda_mode      = io_cfg[IO_MDA_MODE_BIT];
	assign cfg.joy_swap      = io_cfg[IO_JOY_SWAP_BIT];
	assign cfg.splash_active = splash_active_q;

endmodule

`default_nettype wire

//--- hdl/pcxt_glue_top.sv
// PC/XT chipset glue top level
`timescale 1ns/1ps
`default_nettype none

module pcxt_glue_top #(
	parameter int BASE_DIV         = 4,
	parameter int POR_CYCLES       = 65535,
	parameter int CPU_RESET_CYCLES = 43,
	parameter int SPLASH_TICKS     = 14318000,
	parameter int SPLASH_SECONDS   = 5
) (
	input  wire                         clk_chipset,
	input  wire                         reset_wire,
	// Wishbone register port
	input  wire                         wb_cyc,
	input  wire                         wb_stb,
	input  wire                         wb_we,
	input  wire pcxt_pkg::wb_adr_t      wb_adr,
	input  wire pcxt_pkg::wb_data_t     wb_dat_w,
	output wire pcxt_pkg::wb_data_t     wb_dat_r,
	output wire                         wb_ack,
	// Raw inputs
	input  wire                         biu_done,
	input  wire                         opl2_tick_in,
	input  wire                         uart_tick_in,
	input  wire                         ps2_clk_in,
	input  wire                         ps2_data_in,
	// Joysticks
	input  wire pcxt_pkg::joy_digital_t joy0_in,
	input  wire pcxt_pkg::joy_digital_t joy1_in,
	input  wire pcxt_pkg::joy_analog_t  joya0_in,
	input  wire pcxt_pkg::joy_analog_t  joya1_in,
	output wire pcxt_pkg::joy_digital_t joy0,
	output wire pcxt_pkg::joy_digital_t joy1,
	output wire pcxt_pkg::joy_analog_t  joya0,
	output wire pcxt_pkg::joy_analog_t  joya1,
	// PPI
	input  wire [7:0]                   port_b_out,
	output wire pcxt_pkg::dip_nibble_t  port_c_nibble,
	// Sound
	input  wire pcxt_pkg::sample_t      opl2_sample,
	input  wire pcxt_pkg::tandy_sample_t tandy_sample,
	input  wire                         speaker,
	output wire pcxt_pkg::sample_t      audio_out,
	// Enables
	output wire                         cpu_ce,
	output wire                         peripheral_ce,
	output wire                         opl2_ce,
	output wire                         uart_ce,
	output wire                         turbo_mode,
	// System state
	output wire                         sys_reset,
	output wire                         cpu_reset,
	output wire                         tandy_video,
	output wire                         mda_mode,
	output wire                         ps2_clock,
	output wire                         ps2_data
);
	import pcxt_pkg::*;

	ext_ticks_t ext_ticks;
	ps2_lines_t ps2_raw;
	ps2_lines_t ps2_sync;
	logic       base_ce;

	platform_cfg_if cfg_bus ();

	// Pin bundles
	assign ext_ticks = '{opl2: opl2_tick_in, uart: uart_tick_in};
	assign ps2_raw   = '{clk: ps2_clk_in, data: ps2_data_in};
	assign ps2_clock   = ps2_sync.clk;
	assign ps2_data    = ps2_sync.data;
	assign tandy_video = cfg_bus.tandy_video;
	assign mda_mode    = cfg_bus.mda_mode;

	chipset_control #(
		.POR_CYCLES       (POR_CYCLES),
		.CPU_RESET_CYCLES (CPU_RESET_CYCLES),
		.SPLASH_TICKS     (SPLASH_TICKS),
		.SPLASH_SECONDS   (SPLASH_SECONDS)
	) u_control (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.base_ce     (base_ce),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset),
		.cfg         (cfg_bus.ctrl)
	);

	clock_enable_gen #(
		.BASE_DIV (BASE_DIV)
	) u_clk_en (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.biu_done      (biu_done),
		.ext_ticks     (ext_ticks),
		.cfg           (cfg_bus.user),
		.base_ce       (base_ce),
		.cpu_ce        (cpu_ce),
		.peripheral_ce (peripheral_ce),
		.opl2_ce       (opl2_ce),
		.uart_ce       (uart_ce),
		.turbo_mode    (turbo_mode)
	);

	audio_mixer u_mixer (
		.clk_chipset  (clk_chipset),
		.reset_wire   (reset_wire),
		.opl2_sample  (opl2_sample),
		.tandy_sample (tandy_sample),
		.speaker      (speaker),
		.audio_out    (audio_out)
	);

	input_conditioner u_inputs (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.ps2_in        (ps2_raw),
		.ps2_out       (ps2_sync),
		.joy0_in       (joy0_in),
		.joy1_in       (joy1_in),
		.joya0_in      (joya0_in),
		.joya1_in      (joya1_in),
		.joy0          (joy0),
		.joy1          (joy1),
		.joya0         (joya0),
		.joya1         (joya1),
		.port_b_out    (port_b_out),
		.port_c_nibble (port_c_nibble),
		.cfg           (cfg_bus.user)
	);

endmodule

`default_nettype wire

//--- tests/tb_pcxt_checks.svh
// Testbench checks and bus tasks
`ifndef TB_PCXT_CHECKS_SVH
`define TB_PCXT_CHECKS_SVH

// One clock and settle past the edge
task automatic step();
	@(posedge clk_chipset);
	#1;
endtask

task automatic report_failure(input string msg);
	$display("%s", msg);
	$display("SOME TESTS FAILED");
	$fatal(1);
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
	if (act !== exp)
		report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
endtask

task automatic check_joy_digital(input string name, input joy_digital_t exp,
		input joy_digital_t act);
	if (act !== exp)
		report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
endtask

task automatic check_joy_analog(input string name, input joy_analog_t exp,
		input joy_analog_t act);
	if (act !== exp)
		report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
endtask

task automatic check_nibble(input string name, input dip_nibble_t exp, input dip_nibble_t act);
	if (act !== exp)
		report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
endtask

task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
	if (act !== exp)
		report_failure($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
		report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
endtask

// Linear congruential step from the fixed seed
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Wishbone classic single access
task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
		output wb_data_t rdata);
	int waited;
	waited   = 0;
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = we;
	wb_adr   = adr;
	wb_dat_w = wdata;
	do begin
		step();
		waited++;
		if (waited > 8)
			report_failure("Wishbone access never received an ack");
	end while (wb_ack !== 1'b1);
	rdata          = wb_dat_r;
	last_ack_cycle = cycle;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
	step();
	if (wb_ack !== 1'b0)
		report_failure("Wishbone ack stayed high for a second cycle");
	// Idle cycle after the ack
	step();
endtask

task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
	wb_data_t unused;
	wb_access(1'b1, adr, data, unused);
endtask

task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
	wb_access(1'b0, adr, '0, data);
endtask

// Wait out both reset holds and note when each fell
task automatic wait_release(output int sys_fall, output int cpu_fall);
	while (sys_reset !== 1'b0)
		step();
	sys_fall = cycle;
	while (cpu_reset !== 1'b0)
		step();
	cpu_fall = cycle;
endtask

`endif

//--- tests/tb_pcxt_glue.sv
// PC/XT glue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pcxt_glue;
	import pcxt_pkg::*;

	localparam int BASE_DIV         = 2;
	localparam int POR_CYCLES       = 20;
	localparam int CPU_RESET_CYCLES = 43;
	localparam int SPLASH_TICKS     = 10;
	localparam int SPLASH_SECONDS   = 3;
	localparam int SPLASH_CYCLES    = SPLASH_SECONDS * SPLASH_TICKS * BASE_DIV;

	// Run limit from table sizes and the holds
	localparam int TABLE_ROWS  = 2 + 4 + 3 + 4 + 6 + 8 + 8;
	localparam int ENTRY_WAIT  = 64;
	localparam int HOLD_CYCLES = SPLASH_CYCLES + POR_CYCLES + CPU_RESET_CYCLES;
	localparam int LIMIT       = 2 * TABLE_ROWS * ENTRY_WAIT + 2 * HOLD_CYCLES;

	logic clk_chipset, reset_wire;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	wb_adr_t  wb_adr;
	wb_data_t wb_dat_w, wb_dat_r;
	logic biu_done, opl2_tick_in, uart_tick_in, ps2_clk_in, ps2_data_in;
	joy_digital_t joy0_in, joy1_in, joy0, joy1;
	joy_analog_t  joya0_in, joya1_in, joya0, joya1;
	logic [7:0]    port_b_out;
	dip_nibble_t   port_c_nibble;
	sample_t       opl2_sample, audio_out;
	tandy_sample_t tandy_sample;
	logic speaker, cpu_ce, peripheral_ce, opl2_ce, uart_ce, turbo_mode;
	logic sys_reset, cpu_reset, tandy_video, mda_mode, ps2_clock, ps2_data;

	int cycle = 0;
	int last_ack_cycle = 0;
	logic [31:0] lcg_state = 32'h31a5_d835;

	// Stimulus tables
	logic          rst_skip [2]  = '{1'b0, 1'b1};
	wb_data_t      reg_data [4]  = '{32'hdead_beef, 32'h1234_5677, 32'hffff_ffff, 32'h0000_00aa};
	logic          model_tab [3] = '{1'b1, 1'b0, 1'b1};
	cpu_speed_e    spd_tab [4]   = '{SPEED_4_77, SPEED_14_318, SPEED_7_16, SPEED_RSVD};
	int            spd_cpu [4]   = '{8, 24, 12, 8};
	logic          spd_turbo [4] = '{1'b0, 1'b1, 1'b1, 1'b0};
	logic [1:0]    ext_tab [6]   = '{2'b10, 2'b01, 2'b11, 2'b00, 2'b10, 2'b11};
	sample_t       aud_opl [8];
	tandy_sample_t aud_tdy [8];
	logic          aud_spk [8];

	int c0, sys_fall, cpu_fall, pulses, per_pulses, opl_cnt, uart_cnt;
	logic prev_bit, prev_opl, prev_uart;
	wb_data_t rd, exp_rd;
	logic [31:0] r;
	logic [7:0] dip;

	pcxt_glue_top #(
		.BASE_DIV         (BASE_DIV),
		.POR_CYCLES       (POR_CYCLES),
		.CPU_RESET_CYCLES (CPU_RESET_CYCLES),
		.SPLASH_TICKS     (SPLASH_TICKS),
		.SPLASH_SECONDS   (SPLASH_SECONDS)
	) u_dut (.*);

	`include "tb_pcxt_checks.svh"

	initial clk_chipset = 1'b0;
	always #2 clk_chipset = ~clk_chipset;

	always @(posedge clk_chipset) begin
		cycle = cycle + 1;
		if (cycle >= LIMIT)
			report_failure("Timeout: the run exceeded its cycle limit");
	end

	// Mixer rule with 17 bit wrap then bit 0 dropped
	function automatic sample_t mix_expect(input sample_t o, input tandy_sample_t t,
			input logic s);
		int sum;
		logic [16:0] w;
		sum = int'(o) * 4 + (s ? 32768 : 0) + int'(t) * 64;
		w   = sum[16:0];
		return w[16:1];
	endfunction

	task automatic pulse_reset();
		reset_wire = 1'b1;
		step();
		step();
		check_bit("ack in reset", 1'b0, wb_ack);
		check_bit("sys_reset in reset", 1'b1, sys_reset);
		check_bit("cpu_reset in reset", 1'b1, cpu_reset);
		reset_wire = 1'b0;
	endtask

	initial begin
		{reset_wire, wb_cyc, wb_stb, wb_we, biu_done, opl2_tick_in, uart_tick_in} = 7'b100_0000;
		{wb_adr, wb_dat_w, ps2_clk_in, ps2_data_in, port_b_out} = '0;
		{joy0_in, joy1_in, joya0_in, joya1_in} = '0;
		{opl2_sample, tandy_sample, speaker} = '0;

		////////////////////////////////////////////////////////////////////////////
		// Reset sequence with timed splash then early skip
		////////////////////////////////////////////////////////////////////////////
		for (int i = 0; i < 2; i++) begin
			pulse_reset();
			c0 = cycle;
			if (rst_skip[i]) begin
				wb_write(ADR_SYS_CFG, 32'h4);
				wait_release(sys_fall, cpu_fall);
				check_word("skip release", POR_CYCLES + 1, sys_fall - last_ack_cycle);
			end else begin
				wait_release(sys_fall, cpu_fall);
				check_word("splash release", SPLASH_CYCLES + 1 + POR_CYCLES, sys_fall - c0);
				wb_write(ADR_SYS_CFG, 32'h1);
				check_bit("soft reset held", 1'b1, sys_reset);
				wb_write(ADR_SYS_CFG, 32'h0);
				wait_release(sys_fall, cpu_fall);
				check_word("soft release", POR_CYCLES, sys_fall - last_ack_cycle);
			end
			check_word("cpu release", CPU_RESET_CYCLES, cpu_fall - sys_fall);
		end

		// Register access over every address
		for (int i = 0; i < 4; i++) begin
			for (int a = 0; a < 4; a++) begin
				wb_write(wb_adr_t'(a), reg_data[i]);
				wb_read(wb_adr_t'(a), rd);
				exp_rd = (a == 0) ? (reg_data[i] & 32'h1f) :
					(a == 1) ? (reg_data[i] & 32'h3) : 32'h0;
				check_word($sformatf("reg row %0d adr %0d", i, a), exp_rd, rd);
			end
		end
		wb_write(ADR_IO_CFG, 32'h0);
		wb_write(ADR_SYS_CFG, 32'h1);
		wb_write(ADR_SYS_CFG, 32'h0);
		wait_release(sys_fall, cpu_fall);

		// Model latch only across soft reset
		prev_bit = 1'b0;
		for (int i = 0; i < 3; i++) begin
			wb_write(ADR_SYS_CFG, {30'd0, model_tab[i], 1'b0});
			repeat (3) step();
			check_bit($sformatf("model hold %0d", i), prev_bit, tandy_video);
			wb_write(ADR_SYS_CFG, {30'd0, model_tab[i], 1'b1});
			wb_write(ADR_SYS_CFG, {30'd0, model_tab[i], 1'b0});
			wait_release(sys_fall, cpu_fall);
			check_bit($sformatf("model latch %0d", i), model_tab[i], tandy_video);
			prev_bit = model_tab[i];
		end

		////////////////////////////////////////////////////////////////////////////
		// Clock enables over 24 base periods
		////////////////////////////////////////////////////////////////////////////
		prev_bit = 1'b0;
		for (int i = 0; i < 4; i++) begin
			wb_write(ADR_SYS_CFG, {27'd0, spd_tab[i], 3'b000});
			pulses     = 0;
			per_pulses = 0;
			for (int k = 0; k < 24 * BASE_DIV; k++) begin
				step();
				pulses     += int'(cpu_ce);
				per_pulses += int'(peripheral_ce);
			end
			check_word($sformatf("cpu_ce count %0d", i), spd_cpu[i], pulses);
			check_word($sformatf("peripheral_ce count %0d", i), 4, per_pulses);
			check_bit($sformatf("turbo hold %0d", i), prev_bit, turbo_mode);
			biu_done = 1'b1;
			step();
			biu_done = 1'b0;
			step();
			check_bit($sformatf("turbo load %0d", i), spd_turbo[i], turbo_mode);
			prev_bit = spd_turbo[i];
		end

		// External clock edges
		prev_opl  = 1'b0;
		prev_uart = 1'b0;
		for (int i = 0; i < 6; i++) begin
			{opl2_tick_in, uart_tick_in} = ext_tab[i];
			opl_cnt  = 0;
			uart_cnt = 0;
			repeat (5) begin
				step();
				opl_cnt  += int'(opl2_ce);
				uart_cnt += int'(uart_ce);
			end
			check_word($sformatf("opl2_ce row %0d", i), {31'd0, ext_tab[i][1] & ~prev_opl},
				opl_cnt);
			check_word($sformatf("uart_ce row %0d", i), {31'd0, ext_tab[i][0] & ~prev_uart},
				uart_cnt);
			prev_opl  = ext_tab[i][1];
			prev_uart = ext_tab[i][0];
		end

		// Audio corner rows then LCG rows
		aud_opl[0] = 16'sh7fff;
		aud_tdy[0] = 8'hff;
		aud_spk[0] = 1'b1;
		aud_opl[1] = 16'sh8000;
		aud_tdy[1] = 8'h00;
		aud_spk[1] = 1'b0;
		aud_opl[2] = 16'shffff;
		aud_tdy[2] = 8'hff;
		aud_spk[2] = 1'b1;
		aud_opl[3] = 16'sh0000;
		aud_tdy[3] = 8'h00;
		aud_spk[3] = 1'b0;
		for (int i = 4; i < 8; i++) begin
			r = lcg_next();
			aud_opl[i] = r[31:16];
			aud_tdy[i] = r[15:8];
			aud_spk[i] = r[3];
		end
		for (int i = 0; i < 8; i++) begin
			opl2_sample  = aud_opl[i];
			tandy_sample = aud_tdy[i];
			speaker      = aud_spk[i];
			step();
			check_sample($sformatf("audio row %0d", i),
				mix_expect(aud_opl[i], aud_tdy[i], aud_spk[i]), audio_out);
		end

		// Inputs over every swap, mda and port B bit 3 combination
		for (int i = 0; i < 8; i++) begin
			wb_write(ADR_IO_CFG, {30'd0, i[0], i[1]});
			joy0_in  = lcg_next();
			joy1_in  = lcg_next();
			r        = lcg_next();
			joya0_in = r[31:16];
			joya1_in = r[15:0];
			port_b_out  = {4'd0, i[2], 3'b101};
			ps2_clk_in  = i[0] ^ i[2];
			ps2_data_in = ~i[1];
			step();
			check_joy_digital($sformatf("joy0 row %0d", i), i[0] ? joy1_in : joy0_in, joy0);
			check_joy_digital($sformatf("joy1 row %0d", i), i[0] ? joy0_in : joy1_in, joy1);
			check_joy_analog($sformatf("joya0 row %0d", i), i[0] ? joya1_in : joya0_in, joya0);
			check_joy_analog($sformatf("joya1 row %0d", i), i[0] ? joya0_in : joya1_in, joya1);
			dip = i[1] ? 8'b0011_1101 : 8'b0010_1101;
			check_nibble($sformatf("dip row %0d", i), i[2] ? dip[7:4] : dip[3:0], port_c_nibble);
			check_bit($sformatf("mda row %0d", i), i[1], mda_mode);
			step();
			check_bit($sformatf("ps2 clock row %0d", i), ps2_clk_in, ps2_clock);
			check_bit($sformatf("ps2 data row %0d", i), ps2_data_in, ps2_data);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tests
hdl/pcxt_pkg.sv
hdl/platform_cfg_if.sv
hdl/cdc_sync.sv
hdl/clock_enable_gen.sv
hdl/audio_mixer.sv
hdl/input_conditioner.sv
hdl/chipset_control.sv
hdl/pcxt_glue_top.sv
tests/tb_pcxt_glue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the chipset glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pcxt_glue -f sim.f

output=$(./obj_dir/Vtb_pcxt_glue 2>&1) || true
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi
